// ==== rf_ecc_defines.svh ====
// Width, word count and APB register map macros for the ECC register file

`ifndef RF_ECC_DEFINES_SVH
`define RF_ECC_DEFINES_SVH

// Protected word layout
`define RF_DATA_W 32
`define RF_ECC_W 6

// Bank geometry
`define RF_NUM_WORDS 32
`define RF_ADDR_W 5

// APB side
`define APB_ADDR_W 8
`define RF_ERRCNT_W 8

// Control registers sit just above the 32-word register window
`define RF_STATUS_ADDR 8'h80
`define RF_INJECT_ADDR 8'h84

`endif

// ==== rf_ecc_pkg.sv ====
// Word, address, data and count types, APB request/response structs, APB FSM states

`default_nettype none

`include "rf_ecc_defines.svh"

package rf_ecc_pkg;

  // Plain vectors with a meaning
  typedef logic [`RF_DATA_W-1:0]   rf_data_t;
  typedef logic [`RF_ECC_W-1:0]    rf_ecc_t;
  typedef logic [`RF_ADDR_W-1:0]   rf_addr_t;
  typedef logic [`RF_ERRCNT_W-1:0] rf_errcnt_t;

  // Stored word, check bits on top of the data bits
  typedef struct packed {
    rf_ecc_t  ecc;
    rf_data_t data;
  } rf_word_t;

  // Master to slave
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    rf_data_t               pwdata;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    rf_data_t prdata;
    logic     pready;
    logic     pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {IDLE, READ_WAIT, DONE} apb_state_e;

endpackage

`default_nettype wire

// ==== rf_ecc_codec.sv ====
// Hamming check-bit encoder for write data and syndrome checker for read words

`timescale 1ns/1ps
`default_nettype none

`include "rf_ecc_defines.svh"

module rf_ecc_codec (
  // Write side
  input  rf_ecc_pkg::rf_data_t wdata_i,
  output rf_ecc_pkg::rf_word_t wword_o,
  // Read side
  input  rf_ecc_pkg::rf_word_t rword_i,
  output logic                 ecc_err_o
);

  //////////////////////////////////////////////////////////////////////
  // Parity masks
  //////////////////////////////////////////////////////////////////////

  // Practical Hamming distribution, data bits packed first
  // Check bit k covers every data bit whose column has bit k set
  // Every column is distinct and non-zero, so one and two flips both show up
  localparam logic [`RF_ECC_W-1:0][`RF_DATA_W-1:0] ecc_mask = {
    32'b1111_1100_0000_0000_0000_0000_0000_0000,  // c5
    32'b0000_0011_1111_1111_1111_1000_0000_0000,  // c4
    32'b0000_0011_1111_1100_0000_0111_1111_0000,  // c3
    32'b1110_0011_1100_0011_1100_0111_1000_1110,  // c2
    32'b1001_1011_0011_0011_0011_0110_0110_1101,  // c1
    32'b0101_0110_1010_1010_1010_1101_0101_1011   // c0
  };

  //////////////////////////////////////////////////////////////////////
  // Encoder
  //////////////////////////////////////////////////////////////////////

  rf_ecc_pkg::rf_ecc_t ecc;

  always_comb begin
    for (int k = 0; k < `RF_ECC_W; k++) begin
      // Even parity over the selected data bits
      ecc[k] = ^(wdata_i & ecc_mask[k]);
    end
  end

  // Data passes through untouched, check bits ride on top
  assign wword_o.ecc  = ecc;
  assign wword_o.data = wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////////////////////////

  rf_ecc_pkg::rf_ecc_t syndrome;

  always_comb begin
    for (int k = 0; k < `RF_ECC_W; k++) begin
      // Recomputed parity folded with the stored check bit
      syndrome[k] = ^(rword_i.data & ecc_mask[k]) ^ rword_i.ecc[k];
    end
  end

  // Detect only
  // A single flip would be correctable, but any set syndrome bit is just flagged
  // All-zero word has all-zero check bits, so a freshly reset bank is clean
  assign ecc_err_o = |syndrome;

endmodule

`default_nettype wire

// ==== rf_ecc_bank.sv ====
// Flip-flop bank of 32 ECC protected words with a registered read port

`timescale 1ns/1ps
`default_nettype none

`include "rf_ecc_defines.svh"

module rf_ecc_bank (
  input  logic                 clk,
  input  logic                 rst_i,
  // Write port
  input  logic                 we_i,
  input  rf_ecc_pkg::rf_addr_t waddr_i,
  input  rf_ecc_pkg::rf_word_t wword_i,
  // Read port
  input  logic                 re_i,
  input  rf_ecc_pkg::rf_addr_t raddr_i,
  output rf_ecc_pkg::rf_word_t rword_o
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  rf_ecc_pkg::rf_word_t mem_q [`RF_NUM_WORDS];
  rf_ecc_pkg::rf_word_t rword_q;

  // Words clear to zero, which is already a valid codeword
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `RF_NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      // Single cycle write of the full protected word
      mem_q[waddr_i] <= wword_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read register
  //////////////////////////////////////////////////////////////////////

  // Captured on the strobe, held until the next strobe
  // Data shows up the cycle after re_i
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rword_q <= '0;
    end else if (re_i) begin
      rword_q <= mem_q[raddr_i];
    end
  end

  assign rword_o = rword_q;

  // The slave runs one transfer at a time
  // so a write and a read never hit the bank together
  a_no_wr_rd_collision : assert property (
    @(posedge clk) disable iff (rst_i) !(we_i && re_i)
  );

endmodule

`default_nettype wire

// ==== rf_ecc_apb_if.sv ====
// APB slave with address decode, wait states, status/injection registers, error accounting

`timescale 1ns/1ps
`default_nettype none

`include "rf_ecc_defines.svh"

module rf_ecc_apb_if (
  input  logic                 clk,
  input  logic                 rst_i,
  // APB
  input  rf_ecc_pkg::apb_req_t apb_req_i,
  output rf_ecc_pkg::apb_rsp_t apb_rsp_o,
  // Bank control
  output logic                 bank_we_o,
  output logic                 bank_re_o,
  output rf_ecc_pkg::rf_addr_t bank_addr_o,
  // Encoder loop
  output rf_ecc_pkg::rf_data_t enc_wdata_o,
  input  rf_ecc_pkg::rf_word_t enc_wword_i,
  output rf_ecc_pkg::rf_word_t bank_wword_o,
  // Checker loop
  input  rf_ecc_pkg::rf_word_t rword_i,
  input  logic                 ecc_err_i,
  // Sticky error interrupt
  output logic                 irq_o
);

  rf_ecc_pkg::apb_state_e state_q, state_d;
  rf_ecc_pkg::rf_data_t   inj_mask_q;
  rf_ecc_pkg::rf_errcnt_t err_cnt_q;
  rf_ecc_pkg::rf_data_t   status_rdata;
  logic                   err_flag_q;
  logic                   access;
  logic                   is_reg, is_status, is_inject;
  logic                   first_access;
  logic                   status_wr, inject_wr, err_event;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign access    = apb_req_i.psel && apb_req_i.penable;
  assign is_reg    = apb_req_i.paddr < `APB_ADDR_W'(`RF_NUM_WORDS * 4);
  assign is_status = apb_req_i.paddr == `RF_STATUS_ADDR;
  assign is_inject = apb_req_i.paddr == `RF_INJECT_ADDR;

  // Byte address to word index, low two bits ignored
  assign bank_addr_o = apb_req_i.paddr[`RF_ADDR_W+1:2];

  // Encoder sees the clean write data
  // Injection mask flips data bits after the check bits are computed
  assign enc_wdata_o       = apb_req_i.pwdata;
  assign bank_wword_o.ecc  = enc_wword_i.ecc;
  assign bank_wword_o.data = enc_wword_i.data ^ inj_mask_q;

  // Status layout: flag in bit 0, count in 15:8
  always_comb begin
    status_rdata = '0;
    status_rdata[0] = err_flag_q;
    status_rdata[`RF_ERRCNT_W+7:8] = err_cnt_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    apb_rsp_o         = '0;
    bank_we_o         = 1'b0;
    bank_re_o         = 1'b0;
    case (state_q)
      rf_ecc_pkg::IDLE: begin
        if (access) begin
          if (is_reg && !apb_req_i.pwrite) begin
            // Strobe the bank now, answer next cycle
            bank_re_o = 1'b1;
            state_d   = rf_ecc_pkg::READ_WAIT;
          end else begin
            // Everything else finishes in the first access cycle
            apb_rsp_o.pready = 1'b1;
            state_d          = rf_ecc_pkg::DONE;
            if (is_reg) begin
              bank_we_o = 1'b1;
            end else if (is_status) begin
              if (!apb_req_i.pwrite) apb_rsp_o.prdata = status_rdata;
            end else if (!(is_inject && apb_req_i.pwrite)) begin
              // Unmapped, or a read of the write-only injection mask
              apb_rsp_o.pslverr = 1'b1;
            end
          end
        end
      end
      rf_ecc_pkg::READ_WAIT: begin
        // Raw data goes back even when the syndrome is bad
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.prdata  = rword_i.data;
        apb_rsp_o.pslverr = ecc_err_i;
        state_d           = rf_ecc_pkg::DONE;
      end
      rf_ecc_pkg::DONE: begin
        // Wait for the master to leave the access phase
        if (!access) state_d = rf_ecc_pkg::IDLE;
      end
      default: state_d = rf_ecc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) state_q <= rf_ecc_pkg::IDLE;
    else       state_q <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // Control registers and error accounting
  //////////////////////////////////////////////////////////////////////

  assign first_access = (state_q == rf_ecc_pkg::IDLE) && access && apb_req_i.pwrite;
  assign status_wr    = first_access && is_status;
  assign inject_wr    = first_access && is_inject;
  assign err_event    = (state_q == rf_ecc_pkg::READ_WAIT) && ecc_err_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      inj_mask_q <= '0;
      err_flag_q <= 1'b0;
      err_cnt_q  <= '0;
    end else begin
      // Mask is one-shot, consumed by the next register write
      if (inject_wr)      inj_mask_q <= apb_req_i.pwdata;
      else if (bank_we_o) inj_mask_q <= '0;
      // Write 1 to bit 0 clears flag and count together
      if (status_wr && apb_req_i.pwdata[0]) begin
        err_flag_q <= 1'b0;
        err_cnt_q  <= '0;
      end else if (err_event) begin
        err_flag_q <= 1'b1;
        // Saturate at all ones
        if (err_cnt_q != '1) err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  assign irq_o = err_flag_q;

  // Master must hold the request while the slave inserts a wait state
  a_req_stable : assert property (
    @(posedge clk) disable iff (rst_i)
    access && !apb_rsp_o.pready |=> $stable(apb_req_i)
  );

  // Ready only ever shows during an access phase
  a_ready_in_access : assert property (
    @(posedge clk) disable iff (rst_i) apb_rsp_o.pready |-> access
  );

endmodule

`default_nettype wire

// ==== rf_ecc_top.sv ====
// Top level tying together the APB slave, the ECC codec and the protected bank

`timescale 1ns/1ps
`default_nettype none

module rf_ecc_top (
  input  logic                 clk,
  input  logic                 rst_i,
  input  rf_ecc_pkg::apb_req_t apb_req_i,
  output rf_ecc_pkg::apb_rsp_t apb_rsp_o,
  output logic                 irq_o
);

  // Slave to bank
  logic                 bank_we;
  logic                 bank_re;
  rf_ecc_pkg::rf_addr_t bank_addr;
  rf_ecc_pkg::rf_word_t bank_wword;
  // Codec loop
  rf_ecc_pkg::rf_data_t enc_wdata;
  rf_ecc_pkg::rf_word_t enc_wword;
  rf_ecc_pkg::rf_word_t rword;
  logic                 ecc_err;

  rf_ecc_apb_if rf_ecc_apb_if_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .bank_we_o    (bank_we),
    .bank_re_o    (bank_re),
    .bank_addr_o  (bank_addr),
    .enc_wdata_o  (enc_wdata),
    .enc_wword_i  (enc_wword),
    .bank_wword_o (bank_wword),
    .rword_i      (rword),
    .ecc_err_i    (ecc_err),
    .irq_o        (irq_o)
  );

  // Combinational, one encoder and one checker
  rf_ecc_codec rf_ecc_codec_inst (
    .wdata_i   (enc_wdata),
    .wword_o   (enc_wword),
    .rword_i   (rword),
    .ecc_err_o (ecc_err)
  );

  // Single address serves both ports, one transfer at a time
  rf_ecc_bank rf_ecc_bank_inst (
    .clk     (clk),
    .rst_i   (rst_i),
    .we_i    (bank_we),
    .waddr_i (bank_addr),
    .wword_i (bank_wword),
    .re_i    (bank_re),
    .raddr_i (bank_addr),
    .rword_o (rword)
  );

endmodule

`default_nettype wire

// ==== tb_rf_ecc_checks.svh ====
// Compare tasks, LCG function, reference model and stimulus table for the ECC testbench

`ifndef TB_RF_ECC_CHECKS_SVH
`define TB_RF_ECC_CHECKS_SVH

// Reference state, follows the register map rules
logic [31:0]            lcg_state;
rf_ecc_pkg::rf_data_t   model_mem [`RF_NUM_WORDS];
logic                   model_bad [`RF_NUM_WORDS];
rf_ecc_pkg::rf_data_t   model_mask;
rf_ecc_pkg::rf_errcnt_t model_cnt;
logic                   model_flag;

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_data(input rf_ecc_pkg::rf_data_t got, input rf_ecc_pkg::rf_data_t exp,
                          input string what);
  if (got !== exp) begin
    $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_err(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_count(input rf_ecc_pkg::rf_errcnt_t got,
                           input rf_ecc_pkg::rf_errcnt_t exp, input string what);
  if (got !== exp) begin
    $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    stop_on_error();
  end
endtask

// Numerical Recipes constants
function automatic rf_ecc_pkg::rf_data_t lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

//////////////////////////////////////////////////////////////////////
// Table builder
//////////////////////////////////////////////////////////////////////

// Appends one transfer and advances the model past it
function automatic void add_op(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                               input rf_ecc_pkg::rf_data_t wdata);
  op_t e;
  int  idx;
  e       = '0;
  e.wr    = wr;
  e.addr  = addr;
  e.wdata = wdata;
  idx     = addr[`RF_ADDR_W+1:2];
  if (addr < (`RF_NUM_WORDS * 4)) begin
    if (wr) begin
      // Mask lands on the stored data, check bits stay those of the clean data
      model_mem[idx] = wdata ^ model_mask;
      model_bad[idx] = (model_mask != '0);
      model_mask     = '0;
    end else begin
      e.chk_data  = 1'b1;
      e.exp_rdata = model_mem[idx];
      e.exp_err   = model_bad[idx];
      if (model_bad[idx]) begin
        model_flag = 1'b1;
        if (model_cnt != '1) model_cnt = model_cnt + 1'b1;
      end
    end
  end else if (addr == `RF_STATUS_ADDR) begin
    if (wr && wdata[0]) begin
      model_flag = 1'b0;
      model_cnt  = '0;
    end else if (!wr) begin
      e.chk_data  = 1'b1;
      e.chk_cnt   = 1'b1;
      e.exp_rdata = {16'h0, model_cnt, 7'h0, model_flag};
      e.exp_cnt   = model_cnt;
    end
  end else if (addr == `RF_INJECT_ADDR && wr) begin
    model_mask = wdata;
  end else begin
    // Unmapped address or injection read
    e.exp_err = 1'b1;
  end
  e.exp_irq = model_flag;
  ops.push_back(e);
endfunction

task automatic build_table();
  rf_ecc_pkg::rf_data_t flip;
  for (int i = 0; i < `RF_NUM_WORDS; i++) begin
    model_mem[i] = '0;
    model_bad[i] = 1'b0;
  end
  model_mask = '0;
  model_cnt  = '0;
  model_flag = 1'b0;
  // Reset contents are clean zeros
  for (int i = 0; i < `RF_NUM_WORDS; i++) add_op(1'b0, 8'(i * 4), '0);
  add_op(1'b0, `RF_STATUS_ADDR, '0);
  // Random fill and read back
  for (int i = 0; i < `RF_NUM_WORDS; i++) add_op(1'b1, 8'(i * 4), lcg_next());
  for (int i = 0; i < `RF_NUM_WORDS; i++) add_op(1'b0, 8'(i * 4), '0);
  // Single bit injection on word 5, word 6 stays clean
  flip = 32'h1 << (lcg_next() % 32);
  add_op(1'b1, `RF_INJECT_ADDR, flip);
  add_op(1'b1, 8'h14, lcg_next());
  add_op(1'b0, 8'h14, '0);
  add_op(1'b0, 8'h18, '0);
  add_op(1'b0, `RF_STATUS_ADDR, '0);
  // Two bit injection on word 9, one bit in each half
  flip = (32'h1 << (lcg_next() % 16)) | (32'h1 << (16 + lcg_next() % 16));
  add_op(1'b1, `RF_INJECT_ADDR, flip);
  add_op(1'b1, 8'h24, lcg_next());
  add_op(1'b0, 8'h24, '0);
  add_op(1'b0, `RF_STATUS_ADDR, '0);
  // Clear status, repair both words
  add_op(1'b1, `RF_STATUS_ADDR, 32'h1);
  add_op(1'b0, `RF_STATUS_ADDR, '0);
  add_op(1'b1, 8'h14, lcg_next());
  add_op(1'b1, 8'h24, lcg_next());
  add_op(1'b0, 8'h14, '0);
  add_op(1'b0, 8'h24, '0);
  // Error responses, 0x88 aliases word 2 in the low address bits
  add_op(1'b1, 8'h88, lcg_next());
  add_op(1'b0, 8'h88, '0);
  add_op(1'b0, `RF_INJECT_ADDR, '0);
  add_op(1'b1, 8'hfc, lcg_next());
  for (int i = 0; i < `RF_NUM_WORDS; i++) add_op(1'b0, 8'(i * 4), '0);
  add_op(1'b0, `RF_STATUS_ADDR, '0);
endtask

`endif

// ==== tb_rf_ecc.sv ====
// Testbench top for the ECC register file with clock, reset, APB driver and table loop

`timescale 1ns/1ps
`default_nettype none

`include "rf_ecc_defines.svh"

module tb_rf_ecc;

  // Access cycles allowed before pready must show up
  localparam int READY_TIMEOUT = 16;

  // One table entry, expected values filled in while the table is built
  typedef struct packed {
    logic                   wr;
    logic                   chk_data;
    logic                   chk_cnt;
    logic [`APB_ADDR_W-1:0] addr;
    rf_ecc_pkg::rf_data_t   wdata;
    rf_ecc_pkg::rf_data_t   exp_rdata;
    logic                   exp_err;
    logic                   exp_irq;
    rf_ecc_pkg::rf_errcnt_t exp_cnt;
  } op_t;

  logic                 clk;
  logic                 rst_i;
  rf_ecc_pkg::apb_req_t apb_req;
  rf_ecc_pkg::apb_rsp_t apb_rsp;
  logic                 irq;

  op_t                  ops [$];
  op_t                  op;
  rf_ecc_pkg::rf_data_t rdata;
  logic                 err;

  rf_ecc_top rf_ecc_top_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .irq_o     (irq)
  );

  // Single exit point for any failed check or expired wait
  task automatic stop_on_error();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  `include "tb_rf_ecc_checks.svh"

  //////////////////////////////////////////////////////////////////////
  // Clock
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////////////////////////

  // Drive on rising edges, sample on falling edges where outputs are settled
  task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                          input rf_ecc_pkg::rf_data_t wdata,
                          output rf_ecc_pkg::rf_data_t rd, output logic slverr);
    int waited;
    // Setup phase
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    // Access phase, held until the slave answers
    @(posedge clk);
    apb_req.penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1 && waited < READY_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (apb_rsp.pready !== 1'b1) begin
      $display("Timeout: pready stayed low for %0d cycles at address %h", waited, addr);
      stop_on_error();
    end
    rd     = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    // Transfer ends at this edge, bus goes idle
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    apb_req   = '0;
    rst_i     = 1'b1;
    lcg_state = 32'd75;
    build_table();
    // Reset for 4 cycles
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
    for (int n = 0; n < ops.size(); n++) begin
      op = ops[n];
      apb_xfer(op.wr, op.addr, op.wdata, rdata, err);
      check_err(err, op.exp_err, $sformatf("op %0d pslverr at %h", n, op.addr));
      if (op.chk_cnt) begin
        check_count(rdata[`RF_ERRCNT_W+7:8], op.exp_cnt, $sformatf("op %0d error count", n));
      end
      if (op.chk_data) begin
        check_data(rdata, op.exp_rdata, $sformatf("op %0d prdata at %h", n, op.addr));
      end
      // Flag settles at the edge that closes the transfer
      @(negedge clk);
      check_err(irq, op.exp_irq, $sformatf("op %0d irq_o", n));
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
rf_ecc_pkg.sv
rf_ecc_codec.sv
rf_ecc_bank.sv
rf_ecc_apb_if.sv
rf_ecc_top.sv
tb_rf_ecc.sv

// ==== Bender.yml ====
package:
  name: rf_ecc

sources:
  # Design sources in compile order
  - include_dirs:
      - .
    files:
      - rf_ecc_pkg.sv
      - rf_ecc_codec.sv
      - rf_ecc_bank.sv
      - rf_ecc_apb_if.sv
      - rf_ecc_top.sv

  # Testbench, pulls in tb_rf_ecc_checks.svh from the root
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rf_ecc.sv
